//--- bench/ssd_skip_stimulus.txt
# D head value | J group count | B group count (job while busy) | N x0..x7 (stray x)
# X x0..x7 then expected e0..e7, lane 0 first, values in hex
D 0 4000
D 1 3800
D 2 bc00
D 3 3e00
D 4 3c03
D 5 3c01
D 6 7c00
D 7 0400
N 3c00 3c00 3c00 3c00 3c00 3c00 3c00 3c00
J 0 2
X 3c00 4000 3800 bc00 3c00 4000 4200 3e00 4000 4400 3c00 c000 3800 3c00 3e00 3a00
X 3e00 4100 3400 c200 4400 3d00 3a00 be00 4200 4500 3800 c600 4000 3900 3600 ba00
J 1 3
X 3c00 4000 0000 8000 3c00 4000 4200 3800 bc00 c000 8000 0000 3e00 4200 4480 3a00
B 2 5
X 4400 3400 bc00 4600 4400 bc00 3400 4600 c400 b400 3c00 c600 4600 be00 3600 4880
D 3 4000
X 3c00 3c00 3c00 3c00 3c00 3800 4200 bc00 bc00 bc00 bc00 bc00 4000 3c00 4600 c000
N 3c00 3c00 3c00 3c00 3c00 3c00 3c00 3c00
J 2 1
X 3e00 7bff fbff 0200 3e00 7e00 fc00 4000 3e04 7c00 fc00 0000 3e02 7e00 fc00 4001
J 3 1
X 0000 8000 bc00 0200 3800 b800 3bff 4000 7e00 7e00 fc00 7e00 0000 8000 0000 0800

//--- project.f
hw/ssd_skip_pkg.sv
hw/fp16_mul.sv
hw/xd_lane_array.sv
hw/d_param_bank.sv
hw/skip_ctrl_fsm.sv
hw/tile_counter.sv
hw/ssd_skip_top.sv
bench/ssd_skip_assert.sv
bench/ssd_skip_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= ssd_skip_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
RUNFLAGS  ?=

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUNFLAGS)

clean:
	rm -rf $(OBJ_DIR)

//--- bench/ssd_skip_tb.sv
// testbench for the ssd skip stage
// replays the stimulus file, checks products, latency and job flags
`timescale 1ns/1ps

module ssd_skip_tb;

  logic                   clk;
  logic                   rstn;
  logic                   cmd_valid_i;
  ssd_skip_pkg::cmd_t     cmd_i;
  logic                   x_valid_i;
  ssd_skip_pkg::x_tile_t  x_i;
  logic                   out_valid_o;
  ssd_skip_pkg::xd_tile_t out_o;
  logic                   busy_o;
  logic                   done_o;

  // expected tiles and the cycle each one is due
  ssd_skip_pkg::xd_tile_t exp_q [$];
  int                     due_q [$];
  int                     cyc;
  logic [31:0]            lfsr;
  logic                   mon_on;

  ssd_skip_top i_dut (
    .clk         (clk),
    .rstn        (rstn),
    .cmd_valid_i (cmd_valid_i),
    .cmd_i       (cmd_i),
    .x_valid_i   (x_valid_i),
    .x_i         (x_i),
    .out_valid_o (out_valid_o),
    .out_o       (out_o),
    .busy_o      (busy_o),
    .done_o      (done_o)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1, "run stopped at cycle %0d", cyc);
  endtask

  task automatic check_tile(input string name, input ssd_skip_pkg::xd_tile_t got,
                            input ssd_skip_pkg::xd_tile_t exp);
    if (got !== exp) begin
      fail_run($sformatf("Mismatch %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("Mismatch %s got %h expected %h", name, got, exp));
    end
  endtask

  // galois lfsr, x^32+x^22+x^2+x+1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  task automatic random_gap();
    int gap;
    gap = 0;
    for (int i = 0; i < 2; i++) begin
      gap = gap | (int'(lfsr[0]) << i);
      lfsr = lfsr_next(lfsr);
    end
    repeat (gap) @(negedge clk);
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (busy_o) begin
      @(negedge clk);
      n++;
      if (n > 200) begin
        fail_run("timeout waiting for the DUT to leave its job");
      end
    end
  endtask

  task automatic send_cmd(input ssd_skip_pkg::cmd_t c);
    cmd_valid_i = 1'b1;
    cmd_i       = c;
    @(negedge clk);
    cmd_valid_i = 1'b0;
  endtask

  task automatic send_x(input ssd_skip_pkg::x_tile_t t);
    x_valid_i = 1'b1;
    x_i       = t;
    @(negedge clk);
    x_valid_i = 1'b0;
  endtask

  // compares every output cycle against the expected queue
  initial begin
    logic prev_done;
    int   n;
    prev_done = 1'b0;
    n         = 0;
    while (mon_on !== 1'b1) begin
      @(negedge clk);
      n++;
      if (n > 100) begin
        fail_run("timeout waiting for the end of reset");
      end
    end
    forever begin
      @(negedge clk);
      if (prev_done) begin
        check_flag("busy_o", busy_o, 1'b0);
      end
      if (due_q.size() > 0 && due_q[0] == cyc) begin
        check_flag("out_valid_o", out_valid_o, 1'b1);
        check_tile("out_o", out_o, exp_q[0]);
        check_flag("done_o", done_o, exp_q[0].last);
        void'(exp_q.pop_front());
        void'(due_q.pop_front());
      end else begin
        check_flag("out_valid_o", out_valid_o, 1'b0);
        check_flag("done_o", done_o, 1'b0);
      end
      prev_done = done_o;
    end
  end

  initial begin
    int                     fd;
    int                     n;
    int                     jcount;
    int                     jsent;
    byte                    code;
    string                  line;
    logic [15:0]            v [16];
    ssd_skip_pkg::cmd_t     c;
    ssd_skip_pkg::x_tile_t  t;
    ssd_skip_pkg::xd_tile_t e;

    cyc         = 0;
    mon_on      = 1'b0;
    lfsr        = 32'hbb8e_caac;
    rstn        = 1'b1;
    cmd_valid_i = 1'b0;
    cmd_i       = '0;
    x_valid_i   = 1'b0;
    x_i         = '0;
    jcount      = 0;
    jsent       = 0;

    fd = $fopen("bench/ssd_skip_stimulus.txt", "r");
    if (fd == 0) begin
      fail_run("cannot open the stimulus file");
    end

    repeat (16) @(posedge clk);
    mon_on = 1'b1;
    @(negedge clk);
    rstn   = 1'b0;
    @(negedge clk);

    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n == 0 || line.len() < 2) begin
        continue;
      end
      code = line.getc(0);
      if (code == "#") begin
        continue;
      end
      for (int i = 0; i < 16; i++) begin
        v[i] = '0;
      end
      n = $sscanf(line, "%c %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h", code,
                  v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7],
                  v[8], v[9], v[10], v[11], v[12], v[13], v[14], v[15]);
      c = '0;
      for (int i = 0; i < ssd_skip_pkg::LANES; i++) begin
        t.lane[i] = v[i];
        e.data[i] = v[8 + i];
      end
      case (code)
        "D": begin
          c.op      = ssd_skip_pkg::OP_LOAD_D;
          c.head    = v[0][2:0];
          c.d_value = v[1];
          send_cmd(c);
        end
        "J": begin
          wait_idle();
          c.op    = ssd_skip_pkg::OP_JOB;
          c.group = v[0][1:0];
          c.count = v[1][7:0];
          jcount  = int'(v[1][7:0]);
          jsent   = 0;
          send_cmd(c);
          check_flag("busy_o", busy_o, 1'b1);
        end
        // job command while busy must be ignored
        "B": begin
          check_flag("busy_o", busy_o, 1'b1);
          c.op    = ssd_skip_pkg::OP_JOB;
          c.group = v[0][1:0];
          c.count = v[1][7:0];
          send_cmd(c);
        end
        "X": begin
          jsent++;
          e.last = (jsent == jcount);
          exp_q.push_back(e);
          due_q.push_back(cyc + ssd_skip_pkg::MUL_LAT);
          send_x(t);
          random_gap();
        end
        "N": begin
          send_x(t);
        end
        default: begin
          fail_run("unknown record in the stimulus file");
        end
      endcase
    end
    $fclose(fd);

    n = 0;
    while (exp_q.size() > 0 || busy_o) begin
      @(negedge clk);
      n++;
      if (n > 200) begin
        fail_run("timeout waiting for the last results");
      end
    end
    // quiet window, nothing more may come out
    repeat (8) @(negedge clk);
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

//--- bench/ssd_skip_assert.sv
// protocol checks on the skip stage outputs
// done framing, busy release and output latency
`timescale 1ns/1ps

module ssd_skip_assert (
  input logic                   clk,
  input logic                   rstn,
  input logic                   accept_i,
  input logic                   out_valid_i,
  input ssd_skip_pkg::xd_tile_t out_i,
  input logic                   busy_i,
  input logic                   done_i
);

  a_done_with_last: assert property (@(posedge clk) disable iff (rstn)
    done_i |-> (out_valid_i && out_i.last))
    else $error("done without a last output tile");

  a_busy_falls: assert property (@(posedge clk) disable iff (rstn)
    done_i |=> !busy_i)
    else $error("busy still high after done");

  // every output goes back to an accepted tile
  a_out_latency: assert property (@(posedge clk) disable iff (rstn)
    out_valid_i |-> $past(accept_i, ssd_skip_pkg::MUL_LAT))
    else $error("output without an accepted tile before it");

endmodule

bind ssd_skip_top ssd_skip_assert i_assert (
  .clk         (clk),
  .rstn        (rstn),
  .accept_i    (accept),
  .out_valid_i (out_valid_o),
  .out_i       (out_o),
  .busy_i      (busy_o),
  .done_i      (done_o)
);

//--- hw/ssd_skip_top.sv
// skip connection stage, xD = x * D per head
// D bank, job controller, tile counter and multiplier lane array
`timescale 1ns/1ps

module ssd_skip_top (
  input  logic                   clk,
  input  logic                   rstn,
  input  logic                   cmd_valid_i,
  input  ssd_skip_pkg::cmd_t     cmd_i,
  input  logic                   x_valid_i,
  input  ssd_skip_pkg::x_tile_t  x_i,
  output logic                   out_valid_o,
  output ssd_skip_pkg::xd_tile_t out_o,
  output logic                   busy_o,
  output logic                   done_o
);

  logic                           accept;
  logic                           last_tile;
  logic                           tile_clr;
  logic                           tile_inc;
  logic                           drain_clr;
  logic                           drain_inc;
  logic [1:0]                     group;
  logic                           d_wr;
  logic [ssd_skip_pkg::CNT_W-1:0] tile_cnt;
  logic [2:0]                     drain_cnt;
  ssd_skip_pkg::d_group_t         d_group;

  skip_ctrl_fsm i_fsm (
    .clk         (clk),
    .rstn        (rstn),
    .cmd_valid_i (cmd_valid_i),
    .cmd_i       (cmd_i),
    .x_valid_i   (x_valid_i),
    .tile_cnt_i  (tile_cnt),
    .drain_cnt_i (drain_cnt),
    .accept_o    (accept),
    .last_tile_o (last_tile),
    .tile_clr_o  (tile_clr),
    .tile_inc_o  (tile_inc),
    .drain_clr_o (drain_clr),
    .drain_inc_o (drain_inc),
    .group_o     (group),
    .d_wr_o      (d_wr),
    .busy_o      (busy_o),
    .done_o      (done_o)
  );

  tile_counter i_cnt (
    .clk         (clk),
    .rstn        (rstn),
    .tile_clr_i  (tile_clr),
    .tile_inc_i  (tile_inc),
    .drain_clr_i (drain_clr),
    .drain_inc_i (drain_inc),
    .tile_cnt_o  (tile_cnt),
    .drain_cnt_o (drain_cnt)
  );

  d_param_bank i_bank (
    .clk     (clk),
    .rstn    (rstn),
    .wr_i    (d_wr),
    .head_i  (cmd_i.head),
    .value_i (cmd_i.d_value),
    .group_i (group),
    .d_o     (d_group)
  );

  xd_lane_array i_lanes (
    .clk         (clk),
    .rstn        (rstn),
    .valid_i     (accept),
    .last_i      (last_tile),
    .x_i         (x_i),
    .d_i         (d_group),
    .out_valid_o (out_valid_o),
    .out_o       (out_o)
  );

endmodule

//--- hw/tile_counter.sv
// accepted tile and drain cycle counters
// synchronous clear wins over increment
`timescale 1ns/1ps

module tile_counter (
  input  logic                           clk,
  input  logic                           rstn,
  input  logic                           tile_clr_i,
  input  logic                           tile_inc_i,
  input  logic                           drain_clr_i,
  input  logic                           drain_inc_i,
  output logic [ssd_skip_pkg::CNT_W-1:0] tile_cnt_o,
  output logic [2:0]                     drain_cnt_o
);

  logic [ssd_skip_pkg::CNT_W-1:0] tile_q;
  logic [2:0]                     drain_q;

  always_ff @(posedge clk) begin
    if (rstn) begin
      tile_q <= '0;
    end else if (tile_clr_i) begin
      tile_q <= '0;
    end else if (tile_inc_i) begin
      tile_q <= tile_q + 1'b1;
    end
  end

  // cycles since the last accepted tile
  always_ff @(posedge clk) begin
    if (rstn) begin
      drain_q <= '0;
    end else if (drain_clr_i) begin
      drain_q <= '0;
    end else if (drain_inc_i) begin
      drain_q <= drain_q + 1'b1;
    end
  end

  assign tile_cnt_o  = tile_q;
  assign drain_cnt_o = drain_q;

endmodule

//--- hw/skip_ctrl_fsm.sv
// job controller for the skip stage
// opens the x window, marks the last tile, waits out the pipeline
`timescale 1ns/1ps

module skip_ctrl_fsm (
  input  logic                           clk,
  input  logic                           rstn,
  input  logic                           cmd_valid_i,
  input  ssd_skip_pkg::cmd_t             cmd_i,
  input  logic                           x_valid_i,
  input  logic [ssd_skip_pkg::CNT_W-1:0] tile_cnt_i,
  input  logic [2:0]                     drain_cnt_i,
  output logic                           accept_o,
  output logic                           last_tile_o,
  output logic                           tile_clr_o,
  output logic                           tile_inc_o,
  output logic                           drain_clr_o,
  output logic                           drain_inc_o,
  output logic [1:0]                     group_o,
  output logic                           d_wr_o,
  output logic                           busy_o,
  output logic                           done_o
);

  ssd_skip_pkg::skip_state_e state_q, state_d;

  logic [1:0]                     group_q;
  logic [ssd_skip_pkg::CNT_W-1:0] count_q;
  logic [ssd_skip_pkg::CNT_W-1:0] next_cnt;
  logic                           job_cmd;
  logic                           drain_done;

  assign job_cmd = cmd_valid_i && (cmd_i.op == ssd_skip_pkg::OP_JOB);
  assign d_wr_o  = cmd_valid_i && (cmd_i.op == ssd_skip_pkg::OP_LOAD_D);

  assign accept_o    = x_valid_i && (state_q == ssd_skip_pkg::ST_RUN);
  assign next_cnt    = tile_cnt_i + 1'b1;
  assign last_tile_o = accept_o && (next_cnt == count_q);
  assign tile_inc_o  = accept_o;
  assign tile_clr_o  = job_cmd && (state_q == ssd_skip_pkg::ST_IDLE);
  assign drain_clr_o = tile_clr_o;

  // drain count is 1 after the last accept edge, MUL_LAT when it leaves the pipe
  assign drain_done  = (state_q == ssd_skip_pkg::ST_DRAIN) &&
                       (drain_cnt_i == 3'(ssd_skip_pkg::MUL_LAT));
  assign drain_inc_o = last_tile_o ||
                       ((state_q == ssd_skip_pkg::ST_DRAIN) && !drain_done);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ssd_skip_pkg::ST_IDLE:  if (job_cmd) state_d = ssd_skip_pkg::ST_RUN;
      ssd_skip_pkg::ST_RUN:   if (last_tile_o) state_d = ssd_skip_pkg::ST_DRAIN;
      ssd_skip_pkg::ST_DRAIN: if (drain_done) state_d = ssd_skip_pkg::ST_IDLE;
      default:                state_d = ssd_skip_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rstn) begin
      state_q <= ssd_skip_pkg::ST_IDLE;
      group_q <= '0;
      count_q <= '0;
    end else begin
      state_q <= state_d;
      if (tile_clr_o) begin
        group_q <= cmd_i.group;
        count_q <= cmd_i.count;
      end
    end
  end

  assign group_o = group_q;
  assign busy_o  = (state_q != ssd_skip_pkg::ST_IDLE);
  assign done_o  = drain_done;

endmodule

//--- hw/d_param_bank.sv
// per-head skip coefficient bank
// written one head at a time, read one head group at a time
`timescale 1ns/1ps

module d_param_bank (
  input  logic                   clk,
  input  logic                   rstn,
  input  logic                   wr_i,
  input  logic [2:0]             head_i,
  input  logic [15:0]            value_i,
  input  logic [1:0]             group_i,
  output ssd_skip_pkg::d_group_t d_o
);

  logic [15:0] d_q [ssd_skip_pkg::NUM_HEADS];

  always_ff @(posedge clk) begin
    if (rstn) begin
      for (int i = 0; i < ssd_skip_pkg::NUM_HEADS; i++) begin
        d_q[i] <= '0;
      end
    end else if (wr_i) begin
      d_q[head_i] <= value_i;
    end
  end

  // group g covers heads g*H_TILE up to g*H_TILE+H_TILE-1
  always_comb begin
    for (int h = 0; h < ssd_skip_pkg::H_TILE; h++) begin
      d_o.head[h] = d_q[int'(group_i) * ssd_skip_pkg::H_TILE + h];
    end
  end

endmodule

//--- hw/xd_lane_array.sv
// lane array computing x(h,p) * D(h) over one tile
// D of each head is broadcast across its P_TILE lanes
`timescale 1ns/1ps

module xd_lane_array (
  input  logic                   clk,
  input  logic                   rstn,
  input  logic                   valid_i,
  input  logic                   last_i,
  input  ssd_skip_pkg::x_tile_t  x_i,
  input  ssd_skip_pkg::d_group_t d_i,
  output logic                   out_valid_o,
  output ssd_skip_pkg::xd_tile_t out_o
);

  logic [15:0] prod [ssd_skip_pkg::LANES];
  logic        lead_vld;
  logic        lead_last;

  for (genvar h = 0; h < ssd_skip_pkg::H_TILE; h++) begin : g_h
    for (genvar p = 0; p < ssd_skip_pkg::P_TILE; p++) begin : g_p
      localparam int IDX = h * ssd_skip_pkg::P_TILE + p;
      // lane 0 carries valid and last for the whole tile
      if (IDX == 0) begin : g_lead
        fp16_mul i_mul (
          .clk     (clk),
          .rstn    (rstn),
          .valid_i (valid_i),
          .a_i     (x_i.lane[IDX]),
          .b_i     (d_i.head[h]),
          .tag_i   (last_i),
          .valid_o (lead_vld),
          .y_o     (prod[IDX]),
          .tag_o   (lead_last)
        );
      end else begin : g_follow
        fp16_mul i_mul (
          .clk     (clk),
          .rstn    (rstn),
          .valid_i (valid_i),
          .a_i     (x_i.lane[IDX]),
          .b_i     (d_i.head[h]),
          .tag_i   (1'b0),
          .valid_o (),
          .y_o     (prod[IDX]),
          .tag_o   ()
        );
      end
    end
  end

  always_comb begin
    for (int i = 0; i < ssd_skip_pkg::LANES; i++) begin
      out_o.data[i] = prod[i];
    end
    out_o.last = lead_last;
  end

  assign out_valid_o = lead_vld;

endmodule

//--- hw/fp16_mul.sv
// four stage fp16 multiplier
// round to nearest even, subnormals flushed to zero, canonical nan
`timescale 1ns/1ps

module fp16_mul (
  input  logic        clk,
  input  logic        rstn,
  input  logic        valid_i,
  input  logic [15:0] a_i,
  input  logic [15:0] b_i,
  input  logic        tag_i,
  output logic        valid_o,
  output logic [15:0] y_o,
  output logic        tag_o
);

  logic [3:0] vld_q;
  logic [3:0] tag_q;

  // operand classes, exponent 0 counts as zero
  logic a_zero, b_zero, a_inf, b_inf, a_nan, b_nan;

  logic        s1_sign, s1_nan, s1_inf, s1_zero;
  logic [4:0]  s1_ea, s1_eb;
  logic [10:0] s1_ma, s1_mb;

  logic        s2_sign, s2_nan, s2_inf, s2_zero;
  logic [6:0]  s2_esum;
  logic [21:0] s2_prod;

  logic        s3_sign, s3_nan, s3_inf, s3_zero;
  logic [7:0]  s3_exp;
  logic [10:0] s3_sig;
  logic        s3_guard, s3_sticky;

  logic        round_up;
  logic [11:0] sig_rnd;
  logic [7:0]  exp_fin;
  logic [9:0]  mant_fin;
  logic [15:0] result;

  assign a_zero = (a_i[14:10] == 5'd0);
  assign b_zero = (b_i[14:10] == 5'd0);
  assign a_inf  = (a_i[14:10] == 5'h1f) && (a_i[9:0] == 10'd0);
  assign b_inf  = (b_i[14:10] == 5'h1f) && (b_i[9:0] == 10'd0);
  assign a_nan  = (a_i[14:10] == 5'h1f) && (a_i[9:0] != 10'd0);
  assign b_nan  = (b_i[14:10] == 5'h1f) && (b_i[9:0] != 10'd0);

  // valid and tag travel with the data
  always_ff @(posedge clk) begin
    if (rstn) begin
      vld_q <= '0;
      tag_q <= '0;
    end else begin
      vld_q <= {vld_q[2:0], valid_i};
      tag_q <= {tag_q[2:0], tag_i};
    end
  end

  // stage 4 rounding
  assign round_up = s3_guard && (s3_sticky || s3_sig[0]);
  assign sig_rnd  = {1'b0, s3_sig} + {11'd0, round_up};
  assign exp_fin  = s3_exp + {7'd0, sig_rnd[11]};
  assign mant_fin = sig_rnd[11] ? sig_rnd[10:1] : sig_rnd[9:0];

  always_comb begin
    if (s3_nan) begin
      result = ssd_skip_pkg::FP16_QNAN;
    end else if (s3_inf || ($signed(exp_fin) >= 8'sd31)) begin
      result = {s3_sign, 5'h1f, 10'd0};
    end else if (s3_zero || ($signed(exp_fin) <= 8'sd0)) begin
      result = {s3_sign, 15'd0};
    end else begin
      result = {s3_sign, exp_fin[4:0], mant_fin};
    end
  end

  always_ff @(posedge clk) begin
    // stage 1 decode
    s1_sign <= a_i[15] ^ b_i[15];
    s1_nan  <= a_nan || b_nan || (a_inf && b_zero) || (a_zero && b_inf);
    s1_inf  <= a_inf || b_inf;
    s1_zero <= a_zero || b_zero;
    s1_ea   <= a_i[14:10];
    s1_eb   <= b_i[14:10];
    s1_ma   <= {1'b1, a_i[9:0]};
    s1_mb   <= {1'b1, b_i[9:0]};
    // stage 2 significand product
    s2_sign <= s1_sign;
    s2_nan  <= s1_nan;
    s2_inf  <= s1_inf;
    s2_zero <= s1_zero;
    s2_esum <= {2'b00, s1_ea} + {2'b00, s1_eb};
    s2_prod <= s1_ma * s1_mb;
    // stage 3 normalize, product is in [1,4)
    s3_sign <= s2_sign;
    s3_nan  <= s2_nan;
    s3_inf  <= s2_inf;
    s3_zero <= s2_zero;
    s3_exp  <= {1'b0, s2_esum} - 8'd15 + {7'd0, s2_prod[21]};
    if (s2_prod[21]) begin
      s3_sig    <= s2_prod[21:11];
      s3_guard  <= s2_prod[10];
      s3_sticky <= |s2_prod[9:0];
    end else begin
      s3_sig    <= s2_prod[20:10];
      s3_guard  <= s2_prod[9];
      s3_sticky <= |s2_prod[8:0];
    end
    // stage 4 result
    y_o <= result;
  end

  assign valid_o = vld_q[3];
  assign tag_o   = tag_q[3];

endmodule

//--- hw/ssd_skip_pkg.sv
// shared definitions for the ssd skip stage
// tile sizes, controller and opcode enums, command and data buses
package ssd_skip_pkg;

  localparam int DW         = 16;
  localparam int H_TILE     = 2;
  localparam int P_TILE     = 4;
  localparam int LANES      = H_TILE * P_TILE;
  localparam int NUM_HEADS  = 8;
  localparam int NUM_GROUPS = NUM_HEADS / H_TILE;
  localparam int MUL_LAT    = 4;
  localparam int CNT_W      = 8;

  localparam logic [DW-1:0] FP16_QNAN = 16'h7e00;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_RUN,
    ST_DRAIN
  } skip_state_e;

  typedef enum logic {
    OP_LOAD_D,
    OP_JOB
  } cmd_op_e;

  // head is used by OP_LOAD_D, group and count by OP_JOB
  typedef struct packed {
    cmd_op_e                         op;
    logic [$clog2(NUM_HEADS)-1:0]    head;
    logic [$clog2(NUM_GROUPS)-1:0]   group;
    logic [CNT_W-1:0]                count;
    logic [DW-1:0]                   d_value;
  } cmd_t;

  // lane h*P_TILE+p, lane 0 in the low bits
  typedef struct packed {
    logic [LANES-1:0][DW-1:0] lane;
  } x_tile_t;

  typedef struct packed {
    logic [H_TILE-1:0][DW-1:0] head;
  } d_group_t;

  typedef struct packed {
    logic [LANES-1:0][DW-1:0] data;
    logic                     last;
  } xd_tile_t;

endpackage
